// File: verilog/mm_cfg_pkg.sv
`default_nettype none

package mm_cfg_pkg;

  // --------------------
  // data path types

  typedef logic [31:0] word_t;     // operands, commands, results, checksum
  typedef logic [63:0] product_t;  // full multiplier result

  // --------------------
  // default sizes

  localparam int DEF_A_ADDR_W    = 9;  // n up to 512
  localparam int DEF_B_ADDR_W    = 7;  // two pages of 64 words
  localparam int DEF_FIFO_ADDR_W = 4;  // 16 command words
  localparam int DEF_MULT_DEPTH  = 6;

endpackage

`default_nettype wire

// File: verilog/mm_ctrl_pkg.sv
`default_nettype none

package mm_ctrl_pkg;

  // sequencer states
  typedef enum logic [2:0] {
    idle,      // waiting for a size word
    get_size,
    wait_cmd,  // waiting for a computation word
    get_cmd,
    issue      // streaming reads into the multiplier
  } seq_state_t;

  // element and product counts
  typedef logic [31:0] count_t;

endpackage

`default_nettype wire

// File: verilog/mm_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mm_cmd_fifo #(
  parameter int fifo_addr_w = mm_cfg_pkg::DEF_FIFO_ADDR_W
) (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    push,
  input  wire mm_cfg_pkg::word_t push_data,
  input  wire                    pop,
  output logic                   empty,
  output mm_cfg_pkg::word_t      pop_data
);

  mm_cfg_pkg::word_t    mem [2**fifo_addr_w];
  logic [fifo_addr_w:0] wr_ptr;  // top bit tells full from empty
  logic [fifo_addr_w:0] rd_ptr;
  logic                 full;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[fifo_addr_w] != rd_ptr[fifo_addr_w]) &&
                 (wr_ptr[fifo_addr_w-1:0] == rd_ptr[fifo_addr_w-1:0]);

  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage and registered read word
  always_ff @(posedge CLK) begin
    if (push && !full) begin
      mem[wr_ptr[fifo_addr_w-1:0]] <= push_data;
    end
    if (pop && !empty) begin
      pop_data <= mem[rd_ptr[fifo_addr_w-1:0]];
    end
  end

  // host may not overrun, sequencer may not underrun
  a_no_overflow: assert property (@(posedge CLK) disable iff (RST) full |-> !push)
    else $error("command push while FIFO full");
  a_no_underflow: assert property (@(posedge CLK) disable iff (RST) empty |-> !pop)
    else $error("command pop while FIFO empty");

endmodule

`default_nettype wire

// File: verilog/mm_operand_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mm_operand_ram #(
  parameter int addr_w = mm_cfg_pkg::DEF_A_ADDR_W
) (
  input  wire                    CLK,
  input  wire                    we,
  input  wire [addr_w-1:0]       wr_addr,
  input  wire mm_cfg_pkg::word_t wr_data,
  input  wire [addr_w-1:0]       rd_addr,
  output mm_cfg_pkg::word_t      rd_data
);

  mm_cfg_pkg::word_t mem [2**addr_w];

  // host port
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];  // one cycle read latency
  end

endmodule

`default_nettype wire

// File: verilog/mm_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mm_sequencer #(
  parameter int a_addr_w = mm_cfg_pkg::DEF_A_ADDR_W,
  parameter int b_addr_w = mm_cfg_pkg::DEF_B_ADDR_W
) (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    fifo_empty,
  input  wire mm_cfg_pkg::word_t fifo_q,
  output logic                   fifo_pop,
  output logic [a_addr_w-1:0]    a_rd_addr,
  input  wire mm_cfg_pkg::word_t a_q,
  output logic [b_addr_w-1:0]    b_rd_addr,
  input  wire mm_cfg_pkg::word_t b_q,
  output logic                   mul_en,
  output mm_cfg_pkg::word_t      mul_a,
  output mm_cfg_pkg::word_t      mul_b,
  output logic                   mul_last,
  output logic                   session_start,
  output mm_ctrl_pkg::count_t    matrix_size
);

  mm_ctrl_pkg::seq_state_t state;
  mm_ctrl_pkg::count_t     comp_size;  // k of the running computation
  mm_ctrl_pkg::count_t     issue_cnt;  // reads issued so far
  mm_ctrl_pkg::count_t     mul_cnt;    // products handed on since the last tag
  logic                    page;
  logic                    rd_valid;   // RAM read in flight
  logic                    rd_last;
  logic                    a_wrap;
  logic                    issue_done;

  assign a_wrap     = (mm_ctrl_pkg::count_t'(a_rd_addr) == matrix_size - 1);
  assign issue_done = (issue_cnt == comp_size - 1);

  // word is on fifo_q in the state after the pop
  assign fifo_pop = !fifo_empty &&
                    (state == mm_ctrl_pkg::idle || state == mm_ctrl_pkg::wait_cmd);

  // --------------------
  // command FSM and address generation

  always_ff @(posedge CLK) begin
    if (RST) begin
      state         <= mm_ctrl_pkg::idle;
      session_start <= 1'b0;
      matrix_size   <= '0;
      comp_size     <= '0;
      issue_cnt     <= '0;
      page          <= 1'b0;
      a_rd_addr     <= '0;
      b_rd_addr     <= '0;
    end else begin
      session_start <= 1'b0;
      case (state)
        mm_ctrl_pkg::idle: begin
          if (!fifo_empty) begin
            state <= mm_ctrl_pkg::get_size;
          end
        end
        mm_ctrl_pkg::get_size: begin
          matrix_size   <= fifo_q;
          session_start <= 1'b1;  // clears accumulator state
          a_rd_addr     <= '0;
          page          <= 1'b0;
          state         <= mm_ctrl_pkg::wait_cmd;
        end
        mm_ctrl_pkg::wait_cmd: begin
          if (!fifo_empty) begin
            state <= mm_ctrl_pkg::get_cmd;
          end
        end
        mm_ctrl_pkg::get_cmd: begin
          comp_size <= fifo_q;
          issue_cnt <= '0;
          b_rd_addr <= {page, {(b_addr_w-1){1'b0}}};  // page base
          if (fifo_q == '0) begin
            state <= mm_ctrl_pkg::idle;  // end of session
          end else begin
            state <= mm_ctrl_pkg::issue;
          end
        end
        mm_ctrl_pkg::issue: begin
          // A pointer survives into the next computation
          a_rd_addr <= a_wrap ? '0 : a_rd_addr + 1'b1;
          b_rd_addr <= b_rd_addr + 1'b1;
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_done) begin
            page  <= !page;
            state <= mm_ctrl_pkg::wait_cmd;
          end
        end
        default: state <= mm_ctrl_pkg::idle;
      endcase
    end
  end

  // --------------------
  // operand stage

  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
      mul_en   <= 1'b0;
      mul_last <= 1'b0;
    end else begin
      rd_valid <= (state == mm_ctrl_pkg::issue);
      rd_last  <= (state == mm_ctrl_pkg::issue) && issue_done;
      mul_en   <= rd_valid;  // RAM data valid now
      mul_last <= rd_last;
    end
  end

  always_ff @(posedge CLK) begin
    mul_a <= a_q;
    mul_b <= b_q;
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      mul_cnt <= '0;
    end else if (mul_en) begin
      mul_cnt <= mul_last ? '0 : mul_cnt + 1'b1;
    end
  end

  // every computation hands its full k products on
  a_full_issue: assert property (@(posedge CLK) disable iff (RST)
    mul_en && mul_last |-> mul_cnt == comp_size - 1)
    else $error("issue left with count short of k");

endmodule

`default_nettype wire

// File: verilog/mm_signed_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module mm_signed_multiplier #(
  parameter int mult_depth = mm_cfg_pkg::DEF_MULT_DEPTH
) (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    en,
  input  wire mm_cfg_pkg::word_t a,
  input  wire mm_cfg_pkg::word_t b,
  input  wire                    last_in,
  output logic                   valid,
  output mm_cfg_pkg::product_t   rslt,
  output logic                   last_out
);

  localparam int ww = $bits(mm_cfg_pkg::word_t);

  function automatic mm_cfg_pkg::word_t magnitude(mm_cfg_pkg::word_t x);
    return x[ww-1] ? ~x + 1'b1 : x;
  endfunction

  mm_cfg_pkg::word_t    abs_a;
  mm_cfg_pkg::word_t    abs_b;
  mm_cfg_pkg::product_t prod_sr [mult_depth];
  mm_cfg_pkg::product_t mag;
  logic [mult_depth:0]  valid_sr;
  logic [mult_depth:0]  last_sr;
  logic [mult_depth:0]  neg_sr;  // product sign

  // --------------------
  // magnitude data path

  always_ff @(posedge CLK) begin
    abs_a      <= magnitude(a);
    abs_b      <= magnitude(b);
    prod_sr[0] <= mm_cfg_pkg::product_t'(abs_a) * mm_cfg_pkg::product_t'(abs_b);
    for (int i = 1; i < mult_depth; i++) begin
      prod_sr[i] <= prod_sr[i-1];
    end
  end

  // --------------------
  // side chain of the same depth as the data

  always_ff @(posedge CLK) begin
    if (RST) begin
      valid_sr <= '0;
      last_sr  <= '0;
    end else begin
      valid_sr <= {valid_sr[mult_depth-1:0], en};
      last_sr  <= {last_sr[mult_depth-1:0], en && last_in};
    end
  end

  always_ff @(posedge CLK) begin
    neg_sr <= {neg_sr[mult_depth-1:0], a[ww-1] ^ b[ww-1]};
  end

  assign mag      = prod_sr[mult_depth-1];
  assign valid    = valid_sr[mult_depth];
  assign last_out = last_sr[mult_depth];
  assign rslt     = neg_sr[mult_depth] ? ~mag + 1'b1 : mag;  // restore sign

endmodule

`default_nettype wire

// File: verilog/mm_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module mm_accumulator (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       session_start,
  input  wire mm_ctrl_pkg::count_t  matrix_size,
  input  wire                       prod_valid,
  input  wire mm_cfg_pkg::product_t prod_data,
  input  wire                       prod_last,
  output logic                      res_valid,
  output mm_cfg_pkg::word_t         res_data,
  output logic                      sum_valid,
  output mm_cfg_pkg::word_t         sum_data
);

  mm_cfg_pkg::word_t   partial;   // running sum of the open element
  mm_cfg_pkg::word_t   checksum;
  mm_ctrl_pkg::count_t elem_cnt;  // products in the open element
  mm_cfg_pkg::word_t   elem_sum;
  mm_cfg_pkg::word_t   checksum_nxt;
  logic                elem_close;

  // only the low word of each product counts
  assign elem_sum     = partial + prod_data[$bits(mm_cfg_pkg::word_t)-1:0];
  assign elem_close   = prod_valid && (elem_cnt == matrix_size - 1);
  assign checksum_nxt = elem_close ? checksum + elem_sum : checksum;

  always_ff @(posedge CLK) begin
    if (RST) begin
      partial   <= '0;
      checksum  <= '0;
      elem_cnt  <= '0;
      res_valid <= 1'b0;
      sum_valid <= 1'b0;
    end else begin
      res_valid <= elem_close;
      sum_valid <= prod_valid && prod_last;
      if (session_start) begin
        partial  <= '0;
        checksum <= '0;
        elem_cnt <= '0;
      end else if (prod_valid) begin
        checksum <= checksum_nxt;
        if (elem_close) begin
          partial  <= '0;
          elem_cnt <= '0;
        end else begin
          partial  <= elem_sum;
          elem_cnt <= elem_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (elem_close) begin
      res_data <= elem_sum;
    end
    if (prod_valid && prod_last) begin
      sum_data <= checksum_nxt;  // includes the closing element
    end
  end

  a_elem_in_range: assert property (@(posedge CLK) disable iff (RST)
    prod_valid |-> elem_cnt < matrix_size)
    else $error("element counter past matrix size");

endmodule

`default_nettype wire

// File: verilog/mm_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mm_engine #(
  parameter int a_addr_w    = mm_cfg_pkg::DEF_A_ADDR_W,
  parameter int b_addr_w    = mm_cfg_pkg::DEF_B_ADDR_W,
  parameter int fifo_addr_w = mm_cfg_pkg::DEF_FIFO_ADDR_W,
  parameter int mult_depth  = mm_cfg_pkg::DEF_MULT_DEPTH
) (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    a_we,
  input  wire [a_addr_w-1:0]     a_addr,
  input  wire mm_cfg_pkg::word_t a_data,
  input  wire                    b_we,
  input  wire [b_addr_w-1:0]     b_addr,
  input  wire mm_cfg_pkg::word_t b_data,
  input  wire                    cmd_valid,
  input  wire mm_cfg_pkg::word_t cmd_data,
  output wire                    res_valid,
  output wire mm_cfg_pkg::word_t res_data,
  output wire                    sum_valid,
  output wire mm_cfg_pkg::word_t sum_data
);

  wire                       fifo_empty;
  wire                       fifo_pop;
  wire mm_cfg_pkg::word_t    fifo_q;
  wire [a_addr_w-1:0]        a_rd_addr;
  wire [b_addr_w-1:0]        b_rd_addr;
  wire mm_cfg_pkg::word_t    a_q;
  wire mm_cfg_pkg::word_t    b_q;
  wire                       mul_en;
  wire                       mul_last;
  wire mm_cfg_pkg::word_t    mul_a;
  wire mm_cfg_pkg::word_t    mul_b;
  wire                       prod_valid;
  wire                       prod_last;
  wire mm_cfg_pkg::product_t prod_data;
  wire                       session_start;
  wire mm_ctrl_pkg::count_t  matrix_size;

  mm_cmd_fifo #(.fifo_addr_w(fifo_addr_w)) u_cmd_fifo (
    .CLK(CLK), .RST(RST), .push(cmd_valid), .push_data(cmd_data),
    .pop(fifo_pop), .empty(fifo_empty), .pop_data(fifo_q)
  );

  // host loads while the engine reads
  mm_operand_ram #(.addr_w(a_addr_w)) u_ram_a (
    .CLK(CLK), .we(a_we), .wr_addr(a_addr), .wr_data(a_data),
    .rd_addr(a_rd_addr), .rd_data(a_q)
  );

  mm_operand_ram #(.addr_w(b_addr_w)) u_ram_b (
    .CLK(CLK), .we(b_we), .wr_addr(b_addr), .wr_data(b_data),
    .rd_addr(b_rd_addr), .rd_data(b_q)
  );

  mm_sequencer #(.a_addr_w(a_addr_w), .b_addr_w(b_addr_w)) u_sequencer (
    .CLK(CLK), .RST(RST), .fifo_empty(fifo_empty), .fifo_q(fifo_q),
    .fifo_pop(fifo_pop), .a_rd_addr(a_rd_addr), .a_q(a_q),
    .b_rd_addr(b_rd_addr), .b_q(b_q), .mul_en(mul_en), .mul_a(mul_a),
    .mul_b(mul_b), .mul_last(mul_last), .session_start(session_start),
    .matrix_size(matrix_size)
  );

  mm_signed_multiplier #(.mult_depth(mult_depth)) u_mult (
    .CLK(CLK), .RST(RST), .en(mul_en), .a(mul_a), .b(mul_b),
    .last_in(mul_last), .valid(prod_valid), .rslt(prod_data), .last_out(prod_last)
  );

  mm_accumulator u_acc (
    .CLK(CLK), .RST(RST), .session_start(session_start), .matrix_size(matrix_size),
    .prod_valid(prod_valid), .prod_data(prod_data), .prod_last(prod_last),
    .res_valid(res_valid), .res_data(res_data), .sum_valid(sum_valid),
    .sum_data(sum_data)
  );

endmodule

`default_nettype wire

// File: test/tb_mm_model.svh
`ifndef TB_MM_MODEL_SVH
`define TB_MM_MODEL_SVH

// --------------------
// shadow state of the DUT

mm_cfg_pkg::word_t shadow_a [2**mm_cfg_pkg::DEF_A_ADDR_W];
mm_cfg_pkg::word_t shadow_b [2**mm_cfg_pkg::DEF_B_ADDR_W];
mm_cfg_pkg::word_t session_elems [$];  // every element since the size word
logic [31:0]       lfsr_state;
int                model_n;
int                model_ptr;            // A read pointer
logic              model_page;

// --------------------
// random source

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic mm_cfg_pkg::word_t random_word();
  mm_cfg_pkg::word_t w;
  w = '0;
  for (int i = 0; i < 32; i++) begin
    w          = {w[30:0], lfsr_state[0]};  // one bit per step
    lfsr_state = lfsr_step(lfsr_state);
  end
  return w;
endfunction

// --------------------
// reference arithmetic

// low word of the signed 64-bit product
function automatic mm_cfg_pkg::word_t low_product(mm_cfg_pkg::word_t a,
                                                  mm_cfg_pkg::word_t b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [63:0] p;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  p  = sa * sb;
  return p[31:0];
endfunction

// element j of a computation that starts at B address base
function automatic mm_cfg_pkg::word_t ref_element(int base, int p0, int n, int j);
  mm_cfg_pkg::word_t acc;
  acc = '0;
  for (int i = 0; i < n; i++) begin
    acc = acc + low_product(shadow_a[(p0 + j*n + i) % n], shadow_b[base + j*n + i]);
  end
  return acc;
endfunction

function automatic mm_cfg_pkg::word_t ref_checksum(mm_cfg_pkg::word_t elems [$]);
  mm_cfg_pkg::word_t sum;
  sum = '0;
  foreach (elems[i]) begin
    sum = sum + elems[i];  // wraps at 32 bits
  end
  return sum;
endfunction

`endif

// File: test/tb_mm_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mm_engine;

  localparam int a_addr_w = mm_cfg_pkg::DEF_A_ADDR_W;
  localparam int b_addr_w = mm_cfg_pkg::DEF_B_ADDR_W;
  localparam int half_b   = 2**(b_addr_w-1);  // words per B page

  logic                   CLK;
  logic                   RST;
  logic                   a_we;
  logic [a_addr_w-1:0]    a_addr;
  mm_cfg_pkg::word_t      a_data;
  logic                   b_we;
  logic [b_addr_w-1:0]    b_addr;
  mm_cfg_pkg::word_t      b_data;
  logic                   cmd_valid;
  mm_cfg_pkg::word_t      cmd_data;
  wire                    res_valid;
  wire                    sum_valid;
  wire mm_cfg_pkg::word_t res_data;
  wire mm_cfg_pkg::word_t sum_data;

  mm_cfg_pkg::word_t exp_res [$];  // expected elements in order
  mm_cfg_pkg::word_t exp_sum [$];
  string             test_name;

  `include "tb_mm_model.svh"

  mm_engine #(
    .a_addr_w(a_addr_w), .b_addr_w(b_addr_w),
    .fifo_addr_w(mm_cfg_pkg::DEF_FIFO_ADDR_W), .mult_depth(mm_cfg_pkg::DEF_MULT_DEPTH)
  ) uut (
    .CLK(CLK), .RST(RST), .a_we(a_we), .a_addr(a_addr), .a_data(a_data),
    .b_we(b_we), .b_addr(b_addr), .b_data(b_data), .cmd_valid(cmd_valid),
    .cmd_data(cmd_data), .res_valid(res_valid), .res_data(res_data),
    .sum_valid(sum_valid), .sum_data(sum_data)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  // --------------------
  // comparing process on the falling edge where outputs are stable

  always @(negedge CLK) begin
    if (!RST && res_valid) begin
      assert (exp_res.size() > 0)
        else stop_with_error($sformatf("unexpected result strobe in %s", test_name));
      assert (res_data == exp_res[0])
        else stop_with_error($sformatf("** Error %s element: expected %h, actual %h",
                                       test_name, exp_res[0], res_data));
      void'(exp_res.pop_front());
    end
    if (!RST && sum_valid) begin
      assert (exp_sum.size() > 0)
        else stop_with_error($sformatf("unexpected checksum strobe in %s", test_name));
      assert (sum_data == exp_sum[0])
        else stop_with_error($sformatf("** Error %s checksum: expected %h, actual %h",
                                       test_name, exp_sum[0], sum_data));
      void'(exp_sum.pop_front());
    end
  end

  // --------------------
  // host side tasks that start and end on a falling edge

  task automatic write_a(int addr, mm_cfg_pkg::word_t data);
    a_we           = 1'b1;
    a_addr         = addr[a_addr_w-1:0];
    a_data         = data;
    shadow_a[addr] = data;
    @(negedge CLK);
    a_we = 1'b0;
  endtask

  task automatic write_b(int addr, mm_cfg_pkg::word_t data);
    b_we           = 1'b1;
    b_addr         = addr[b_addr_w-1:0];
    b_data         = data;
    shadow_b[addr] = data;
    @(negedge CLK);
    b_we = 1'b0;
  endtask

  task automatic push_cmd(mm_cfg_pkg::word_t w);
    cmd_valid = 1'b1;
    cmd_data  = w;
    @(negedge CLK);
    cmd_valid = 1'b0;
  endtask

  task automatic start_session(int n);
    push_cmd(mm_cfg_pkg::word_t'(n));
    model_n    = n;
    model_ptr  = 0;
    model_page = 1'b0;
    session_elems.delete();  // checksum restarts
  endtask

  task automatic run_comp(int k);
    int                base;
    mm_cfg_pkg::word_t elem;
    base = model_page ? half_b : 0;
    push_cmd(mm_cfg_pkg::word_t'(k));
    for (int j = 0; j < k / model_n; j++) begin
      elem = ref_element(base, model_ptr, model_n, j);
      exp_res.push_back(elem);
      session_elems.push_back(elem);
    end
    exp_sum.push_back(ref_checksum(session_elems));
    model_ptr  = (model_ptr + k) % model_n;
    model_page = !model_page;
  endtask

  task automatic wait_drained(int limit);
    int cycles;
    cycles = 0;
    while (exp_res.size() > 0 || exp_sum.size() > 0) begin
      @(negedge CLK);
      cycles++;
      assert (cycles < limit)
        else stop_with_error($sformatf("timeout in %s waiting for result strobes", test_name));
    end
  endtask

  // --------------------
  // stimulus

  initial begin
    mm_cfg_pkg::word_t ext_a [4];
    mm_cfg_pkg::word_t ext_b [8];
    RST        = 1'b1;
    a_we       = 1'b0;
    a_addr     = '0;
    a_data     = '0;
    b_we       = 1'b0;
    b_addr     = '0;
    b_data     = '0;
    cmd_valid  = 1'b0;
    cmd_data   = '0;
    lfsr_state = 32'h17df;
    test_name  = "reset";
    repeat (10) @(negedge CLK);
    RST = 1'b0;

    test_name = "page0";
    for (int i = 0; i < 4; i++) write_a(i, random_word());
    for (int i = 0; i < 2*half_b; i++) write_b(i, random_word());
    start_session(4);
    run_comp(8);
    wait_drained(500);

    test_name = "page1";  // checksum carries the page 0 elements
    run_comp(8);
    wait_drained(500);

    // page 0 again with both signs and the most negative word
    test_name = "extremes";
    ext_a = '{32'h80000000, 32'hffffffff, 32'h7fffffff, 32'h80000000};
    ext_b = '{32'h80000000, 32'hffffffff, 32'h7fffffff, 32'hfffffffb,
              32'h00000001, 32'hffffffff, 32'h80000000, 32'h00000002};
    for (int i = 0; i < 4; i++) write_a(i, ext_a[i]);
    for (int i = 0; i < 8; i++) write_b(i, ext_b[i]);
    run_comp(8);
    wait_drained(500);
    push_cmd('0);

    test_name = "resize";
    for (int i = 0; i < 3; i++) write_a(i, random_word());
    start_session(3);
    run_comp(6);
    push_cmd('0);
    wait_drained(500);

    test_name = "back_to_back";
    for (int i = 0; i < 2; i++) write_a(i, random_word());
    for (int i = 0; i < 2*half_b; i++) write_b(i, random_word());
    start_session(2);
    run_comp(4);
    run_comp(6);
    run_comp(8);
    push_cmd('0);
    wait_drained(1000);

    repeat (20) @(negedge CLK);  // catch stray strobes
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+test
verilog/mm_cfg_pkg.sv
verilog/mm_ctrl_pkg.sv
verilog/mm_cmd_fifo.sv
verilog/mm_operand_ram.sv
verilog/mm_sequencer.sv
verilog/mm_signed_multiplier.sv
verilog/mm_accumulator.sv
verilog/mm_engine.sv
test/tb_mm_engine.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_mm_engine
FILELIST  = filelist.f
BUILD     = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero on $fatal
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
